// File: cal_monitor_top.sv
/*
  Two-channel link calibration monitor.
  Each channel takes a neg-edge and a pos-edge word per cycle, valid bit in
  the MSB, already captured in the clk domain. Results are read over APB.
*/
`timescale 1ns/1ps
`include "cal_params.svh"

module cal_monitor_top (
    input  logic               clk,
    input  logic               reset,
    input  cal_pkg::apb_addr_t paddr_i,
    input  logic               psel_i,
    input  logic               penable_i,
    input  logic               pwrite_i,
    input  cal_pkg::apb_data_t pwdata_i,
    output cal_pkg::apb_data_t prdata_o,
    output logic               pready_o,
    output logic               pslverr_o,
    input  cal_pkg::cal_word_t neg0_i,
    input  cal_pkg::cal_word_t pos0_i,
    input  cal_pkg::cal_word_t neg1_i,
    input  cal_pkg::cal_word_t pos1_i
);
    import cal_pkg::*;

    logic [`CAL_NUM_CH-1:0] ch_enable;
    logic                   stat_we;
    cal_chan_t              stat_ch;
    cal_status_t            stat_data;

    cal_result_if rpt0_if ();
    cal_result_if rpt1_if ();

    fs_pattern_checker u_chk0 (
        .clk      (clk),
        .reset    (reset),
        .enable_i (ch_enable[0]),
        .neg_i    (neg0_i),
        .pos_i    (pos0_i),
        .rpt      (rpt0_if.reporter)
    );

    fs_pattern_checker u_chk1 (
        .clk      (clk),
        .reset    (reset),
        .enable_i (ch_enable[1]),
        .neg_i    (neg1_i),
        .pos_i    (pos1_i),
        .rpt      (rpt1_if.reporter)
    );

    cal_result_arbiter u_arb (
        .clk         (clk),
        .reset       (reset),
        .rpt0        (rpt0_if.arbiter),
        .rpt1        (rpt1_if.arbiter),
        .stat_we_o   (stat_we),
        .stat_ch_o   (stat_ch),
        .stat_data_o (stat_data)
    );

    cal_status_regs u_regs (
        .clk         (clk),
        .reset       (reset),
        .paddr_i     (paddr_i),
        .psel_i      (psel_i),
        .penable_i   (penable_i),
        .pwrite_i    (pwrite_i),
        .pwdata_i    (pwdata_i),
        .prdata_o    (prdata_o),
        .pready_o    (pready_o),
        .pslverr_o   (pslverr_o),
        .stat_we_i   (stat_we),
        .stat_ch_i   (stat_ch),
        .stat_data_i (stat_data),
        .ch_enable_o (ch_enable)
    );

endmodule

// File: cal_params.svh
/*
  Project-wide constants for the link calibration monitor.
  The status word layout assumes CAL_STREAK_W is at most 24.
  The register map only decodes two status words, so CAL_NUM_CH must stay 2.
  APB offsets are byte addresses on an 8-bit address bus.
*/
`ifndef CAL_PARAMS_SVH
`define CAL_PARAMS_SVH

// Data bits carried by one edge word, valid bit excluded.
`define CAL_DATA_W 8

`define CAL_NUM_CH 2

// Words per calibration round and the pass / fail limits.
`define CAL_WORDS_PER_ROUND 16
`define CAL_THRESHOLD 12
`define CAL_TIMEOUT 24

`define CAL_STREAK_W 8

// APB register offsets.
`define CAL_ADDR_CTRL 8'h00
`define CAL_ADDR_STAT0 8'h04
`define CAL_ADDR_STAT1 8'h08

`endif

// File: cal_pkg.sv
/*
  Shared types for the calibration monitor and its testbench.
  Widths come from the project constants header.
  Status word layout: bit 0 done, bit 1 success, bit 2 timed_out,
  bits 15:8 streak, all other bits zero.
*/
`include "cal_params.svh"

package cal_pkg;

    // One edge word is a valid bit above the data.
    typedef logic [`CAL_DATA_W-1:0] cal_data_t;
    typedef logic [`CAL_DATA_W:0]   cal_word_t;

    typedef logic [`CAL_STREAK_W-1:0] cal_streak_t;

    typedef logic [0:0] cal_chan_t;

    typedef logic [31:0] cal_status_t;

    // APB bus fields.
    typedef logic [7:0]  apb_addr_t;
    typedef logic [31:0] apb_data_t;

    // Which channel the arbiter served last.
    typedef enum logic {
        LAST_CH0,
        LAST_CH1
    } arb_state_t;

endpackage

// File: cal_result_arbiter.sv
/*
  Round-robin arbiter between the two checker reports.
  The grant is combinational in the cycle of the request; on a tie the
  channel not served last wins, and the other is served next cycle.
  The granted report is packed into a status word with done set.
*/
`timescale 1ns/1ps
`include "cal_params.svh"

module cal_result_arbiter (
    input  logic                 clk,
    input  logic                 reset,
    cal_result_if.arbiter        rpt0,
    cal_result_if.arbiter        rpt1,
    output logic                 stat_we_o,
    output cal_pkg::cal_chan_t   stat_ch_o,
    output cal_pkg::cal_status_t stat_data_o
);
    import cal_pkg::*;

    arb_state_t  last_r;
    logic        gnt0;
    logic        gnt1;
    logic        sel_success;
    logic        sel_timed_out;
    cal_streak_t sel_streak;

    // Channel 0 wins unless channel 1 also asks and 0 was served last.
    assign gnt0 = rpt0.req && (!rpt1.req || last_r == LAST_CH1);
    assign gnt1 = rpt1.req && !gnt0;

    assign rpt0.gnt = gnt0;
    assign rpt1.gnt = gnt1;

    always_ff @(posedge clk) begin
        if (reset) begin
            last_r <= LAST_CH1;
        end else if (gnt0) begin
            last_r <= LAST_CH0;
        end else if (gnt1) begin
            last_r <= LAST_CH1;
        end
    end

    assign sel_success   = gnt1 ? rpt1.success   : rpt0.success;
    assign sel_timed_out = gnt1 ? rpt1.timed_out : rpt0.timed_out;
    assign sel_streak    = gnt1 ? rpt1.streak    : rpt0.streak;

    assign stat_we_o = gnt0 || gnt1;
    assign stat_ch_o = gnt1;

    // Streak in bits 15:8, flags in bits 2:0.
    assign stat_data_o = {{(24 - `CAL_STREAK_W){1'b0}}, sel_streak, 5'b0,
                          sel_timed_out, sel_success, 1'b1};

    // Status block has a single write port.
    a_one_grant: assert property (@(posedge clk) disable iff (reset)
        $onehot0({rpt0.gnt, rpt1.gnt}))
        else $error("both channels granted in one cycle");

endmodule

// File: cal_result_if.sv
/*
  Round report from one pattern checker to the result arbiter.
  req rises with the fields stable and stays high until a cycle with gnt.
  That cycle transfers the report, and req drops on the following edge.
  gnt is only high while req is high.
*/
`timescale 1ns/1ps

interface cal_result_if;
    import cal_pkg::*;

    logic        req;
    logic        gnt;
    logic        success;
    logic        timed_out;
    cal_streak_t streak;

    // Checker side.
    modport reporter (
        output req,
        output success,
        output timed_out,
        output streak,
        input  gnt
    );

    // Arbiter side.
    modport arbiter (
        input  req,
        input  success,
        input  timed_out,
        input  streak,
        output gnt
    );

endinterface

// File: cal_status_regs.sv
/*
  APB slave with the channel enable register and one status word per channel.
  pready is high in every cycle after reset, so transfers take two cycles.
  pslverr flags unmapped addresses and writes to the read-only status words;
  such writes change nothing. Clearing an enable bit zeros that status word.
*/
`timescale 1ns/1ps
`include "cal_params.svh"

module cal_status_regs (
    input  logic                    clk,
    input  logic                    reset,
    input  cal_pkg::apb_addr_t      paddr_i,
    input  logic                    psel_i,
    input  logic                    penable_i,
    input  logic                    pwrite_i,
    input  cal_pkg::apb_data_t      pwdata_i,
    output cal_pkg::apb_data_t      prdata_o,
    output logic                    pready_o,
    output logic                    pslverr_o,
    input  logic                    stat_we_i,
    input  cal_pkg::cal_chan_t      stat_ch_i,
    input  cal_pkg::cal_status_t    stat_data_i,
    output logic [`CAL_NUM_CH-1:0]  ch_enable_o
);
    import cal_pkg::*;

    logic [`CAL_NUM_CH-1:0] ctrl_r;
    cal_status_t            stat_r [`CAL_NUM_CH];
    logic                   setup;
    logic                   access;
    logic                   hit_ctrl;
    logic                   hit_stat;
    logic                   addr_err;
    logic                   ctrl_we;
    logic                   pready_r;
    logic                   pslverr_r;

    assign setup    = psel_i && !penable_i;
    assign access   = psel_i && penable_i;
    assign hit_ctrl = paddr_i == `CAL_ADDR_CTRL;
    assign hit_stat = (paddr_i == `CAL_ADDR_STAT0) || (paddr_i == `CAL_ADDR_STAT1);
    assign addr_err = !(hit_ctrl || hit_stat) || (pwrite_i && hit_stat);
    assign ctrl_we  = access && pwrite_i && hit_ctrl;

    always_ff @(posedge clk) begin
        if (reset) begin
            ctrl_r <= '0;
        end else if (ctrl_we) begin
            ctrl_r <= pwdata_i[`CAL_NUM_CH-1:0];
        end
    end

    // Disable clear takes priority over a report landing in the same cycle.
    always_ff @(posedge clk) begin
        if (reset) begin
            for (int i = 0; i < `CAL_NUM_CH; i++) begin
                stat_r[i] <= '0;
            end
        end else begin
            if (stat_we_i) begin
                stat_r[stat_ch_i] <= stat_data_i;
            end
            for (int i = 0; i < `CAL_NUM_CH; i++) begin
                if (ctrl_we && ctrl_r[i] && !pwdata_i[i]) begin
                    stat_r[i] <= '0;
                end
            end
        end
    end

    // Error is decoded in the setup phase and shown during access.
    always_ff @(posedge clk) begin
        if (reset) begin
            pready_r  <= 1'b0;
            pslverr_r <= 1'b0;
        end else begin
            pready_r  <= 1'b1;
            pslverr_r <= setup && addr_err;
        end
    end

    always_comb begin
        prdata_o = '0;
        case (paddr_i)
            `CAL_ADDR_CTRL:  prdata_o[`CAL_NUM_CH-1:0] = ctrl_r;
            `CAL_ADDR_STAT0: prdata_o = stat_r[0];
            `CAL_ADDR_STAT1: prdata_o = stat_r[1];
            default:         prdata_o = '0;
        endcase
    end

    assign pready_o    = pready_r;
    assign pslverr_o   = pslverr_r;
    assign ch_enable_o = ctrl_r;

endmodule

// File: fs_pattern_checker.sv
/*
  Incrementing-counter checker for one source-synchronous channel.
  The neg-edge word is taken before the pos-edge word in the same cycle.
  Only one previous word of history is kept; the first word after enable
  always restarts the streak. Disabling clears streak, total and round count.
  A new round must not end while the previous report is still ungranted.
*/
`timescale 1ns/1ps
`include "cal_params.svh"

module fs_pattern_checker (
    input  logic               clk,
    input  logic               reset,
    input  logic               enable_i,
    input  cal_pkg::cal_word_t neg_i,
    input  cal_pkg::cal_word_t pos_i,
    cal_result_if.reporter     rpt
);
    import cal_pkg::*;

    localparam int unsigned ROUND_W = $clog2(`CAL_WORDS_PER_ROUND) + 2;
    localparam int unsigned TOTAL_W = $clog2(`CAL_TIMEOUT) + 2;

    logic               neg_v;
    logic               pos_v;
    cal_data_t          neg_d;
    cal_data_t          pos_d;
    logic [1:0]         word_cnt;
    cal_data_t          last_r;
    cal_data_t          last_mid;
    cal_data_t          last_n;
    logic               have_r;
    logic               have_mid;
    logic               have_n;
    cal_streak_t        streak_r;
    cal_streak_t        streak_mid;
    cal_streak_t        streak_n;
    logic [TOTAL_W-1:0] total_r;
    logic [TOTAL_W-1:0] total_n;
    logic [ROUND_W-1:0] round_r;
    logic [ROUND_W-1:0] round_sum;
    logic [ROUND_W-1:0] round_n;
    logic               round_end;
    logic               success_n;
    logic               timed_out_n;
    logic               req_r;
    logic               success_r;
    logic               timed_out_r;
    cal_streak_t        rpt_streak_r;

    // Streak after one arriving word, saturating at the counter maximum.
    function automatic cal_streak_t next_streak(input logic        have,
                                                input cal_data_t   prev,
                                                input cal_data_t   cur,
                                                input cal_streak_t s);
        if (!have || cur != cal_data_t'(prev + 1'b1)) begin
            return '0;
        end
        if (s == '1) begin
            return s;
        end
        return s + 1'b1;
    endfunction

    assign neg_v = neg_i[`CAL_DATA_W];
    assign pos_v = pos_i[`CAL_DATA_W];
    assign neg_d = neg_i[`CAL_DATA_W-1:0];
    assign pos_d = pos_i[`CAL_DATA_W-1:0];
    assign word_cnt = {1'b0, neg_v} + {1'b0, pos_v};

    // Apply the neg word first, then the pos word against the updated history.
    always_comb begin
        last_mid   = last_r;
        have_mid   = have_r;
        streak_mid = streak_r;
        if (neg_v) begin
            streak_mid = next_streak(have_r, last_r, neg_d, streak_r);
            last_mid   = neg_d;
            have_mid   = 1'b1;
        end
        last_n   = last_mid;
        have_n   = have_mid;
        streak_n = streak_mid;
        if (pos_v) begin
            streak_n = next_streak(have_mid, last_mid, pos_d, streak_mid);
            last_n   = pos_d;
            have_n   = 1'b1;
        end
    end

    // Total word count only needs to reach the timeout, so it saturates there.
    always_comb begin
        total_n = total_r + TOTAL_W'(word_cnt);
        if (total_n > TOTAL_W'(`CAL_TIMEOUT)) begin
            total_n = TOTAL_W'(`CAL_TIMEOUT);
        end
    end

    assign round_sum = round_r + ROUND_W'(word_cnt);
    assign round_end = enable_i && (round_sum >= ROUND_W'(`CAL_WORDS_PER_ROUND));
    assign round_n = round_end ? round_sum - ROUND_W'(`CAL_WORDS_PER_ROUND) : round_sum;

    assign success_n = streak_n >= cal_streak_t'(`CAL_THRESHOLD);
    assign timed_out_n = (total_n >= TOTAL_W'(`CAL_TIMEOUT)) && !success_n;

    always_ff @(posedge clk) begin
        if (reset || !enable_i) begin
            have_r   <= 1'b0;
            streak_r <= '0;
            total_r  <= '0;
            round_r  <= '0;
        end else begin
            have_r   <= have_n;
            streak_r <= streak_n;
            total_r  <= total_n;
            round_r  <= round_n;
        end
    end

    // Last word is only compared once have_r is set.
    always_ff @(posedge clk) begin
        last_r <= last_n;
    end

    // A round end raises req; a grant drops it on the next edge.
    always_ff @(posedge clk) begin
        if (reset) begin
            req_r <= 1'b0;
        end else if (round_end) begin
            req_r <= 1'b1;
        end else if (rpt.gnt) begin
            req_r <= 1'b0;
        end
    end

    always_ff @(posedge clk) begin
        if (round_end) begin
            success_r    <= success_n;
            timed_out_r  <= timed_out_n;
            rpt_streak_r <= streak_n;
        end
    end

    assign rpt.req       = req_r;
    assign rpt.success   = success_r;
    assign rpt.timed_out = timed_out_r;
    assign rpt.streak    = rpt_streak_r;

    // Report stays offered until the arbiter takes it.
    a_req_held: assert property (@(posedge clk) disable iff (reset)
        rpt.req && !rpt.gnt |=> rpt.req)
        else $error("req dropped before grant");

    // Arbiter latency must be shorter than a round.
    a_no_overrun: assert property (@(posedge clk) disable iff (reset)
        round_end |-> !rpt.req || rpt.gnt)
        else $error("round ended with a report still pending");

endmodule

// File: run.sh
#!/bin/sh
# Builds and runs the calibration monitor testbench with Verilator.
# The exit status is nonzero if the build fails or the simulation fails.

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert --top-module tb_cal_monitor -f vlog.f
status=$?
if [ "$status" -ne 0 ]; then
    echo "Verilator build failed with status $status"
    exit "$status"
fi

./obj_dir/Vtb_cal_monitor
status=$?
if [ "$status" -ne 0 ]; then
    echo "Simulation failed with status $status"
    exit "$status"
fi

exit 0

// File: tb_cal_monitor.sv
/*
  Table-driven testbench for the two-channel calibration monitor.
  Each row streams whole rounds of words, polls the status over APB and
  compares the last round's report. Row positions are 1-based and 0 means none.
  A reference model recomputes each row's report from the sequence rules.
  The run stops at the first error.
*/
`timescale 1ns/1ps
`include "cal_params.svh"

module tb_cal_monitor;
    import cal_pkg::*;

    localparam int NUM_ROWS       = 6;
    localparam int BOTH           = 2;
    localparam int APB_TIMEOUT    = 16;
    localparam int DONE_POLLS     = 20;
    localparam int REPORT_LATENCY = 3;
    localparam cal_data_t CH1_OFFSET = 8'h80;

    logic      clk;
    logic      reset;
    apb_addr_t paddr;
    logic      psel;
    logic      penable;
    logic      pwrite;
    apb_data_t pwdata;
    apb_data_t prdata;
    logic      pready;
    logic      pslverr;
    cal_word_t neg0;
    cal_word_t pos0;
    cal_word_t neg1;
    cal_word_t pos1;

    // Arrival order of the current row's words as the checker sees them.
    cal_data_t words_q [$];

    // The columns are name, channel, start, words, corrupt pos, swap cycle, both edges
    // and step, then expected success, timed_out and streak of the last report.
    string row_name [NUM_ROWS] = '{"clean_ch0", "corrupt_pos8", "both_edges_clean",
                                   "both_edges_swap", "const_timeout", "dual_channel"};
    int row_chan       [NUM_ROWS] = '{0, 0, 0, 0, 1, BOTH};
    int row_start      [NUM_ROWS] = '{8'h10, 8'h3c, 8'hf8, 8'h20, 8'ha5, 8'h00};
    int row_words      [NUM_ROWS] = '{16, 16, 16, 16, 32, 16};
    int row_corrupt    [NUM_ROWS] = '{0, 8, 0, 0, 0, 0};
    int row_swap       [NUM_ROWS] = '{0, 0, 0, 4, 0, 0};
    bit row_both       [NUM_ROWS] = '{1'b0, 1'b0, 1'b1, 1'b1, 1'b0, 1'b0};
    int row_step       [NUM_ROWS] = '{1, 1, 1, 1, 0, 1};
    bit row_exp_succ   [NUM_ROWS] = '{1'b1, 1'b0, 1'b1, 1'b0, 1'b0, 1'b1};
    bit row_exp_tmo    [NUM_ROWS] = '{1'b0, 1'b0, 1'b0, 1'b0, 1'b1, 1'b0};
    int row_exp_streak [NUM_ROWS] = '{15, 7, 15, 7, 0, 15};

    cal_monitor_top dut_i (
        .clk       (clk),
        .reset     (reset),
        .paddr_i   (paddr),
        .psel_i    (psel),
        .penable_i (penable),
        .pwrite_i  (pwrite),
        .pwdata_i  (pwdata),
        .prdata_o  (prdata),
        .pready_o  (pready),
        .pslverr_o (pslverr),
        .neg0_i    (neg0),
        .pos0_i    (pos0),
        .neg1_i    (neg1),
        .pos1_i    (pos1)
    );

    initial begin
        clk = 1'b0;
        forever #20 clk = ~clk;
    end

    task automatic fail_now(input string msg);
        $display("%s", msg);
        $display("TEST FAILED");
        $fatal(1, "stopping on the first error");
    endtask

    task automatic check_eq(input string what, input logic [31:0] exp, input logic [31:0] act);
        assert (act === exp) else begin
            fail_now($sformatf("error %s: expected 0x%08h, actual 0x%08h", what, exp, act));
        end
    endtask

    // One APB transfer with outputs sampled on the falling edge of the access phase.
    task automatic apb_xfer(input logic wr, input apb_addr_t addr, input apb_data_t wdata,
                            output apb_data_t rdata, output logic err);
        int waits;
        @(posedge clk);
        psel    <= 1'b1;
        penable <= 1'b0;
        pwrite  <= wr;
        paddr   <= addr;
        pwdata  <= wdata;
        @(posedge clk);
        penable <= 1'b1;
        waits = 0;
        @(negedge clk);
        while (!pready) begin
            waits++;
            assert (waits < APB_TIMEOUT) else begin
                fail_now($sformatf("APB slave never raised pready at address 0x%02h", addr));
            end
            @(negedge clk);
        end
        rdata = prdata;
        err   = pslverr;
        @(posedge clk);
        psel    <= 1'b0;
        penable <= 1'b0;
        pwrite  <= 1'b0;
    endtask

    task automatic apb_write(input apb_addr_t addr, input apb_data_t wdata);
        apb_data_t rdata;
        logic      err;
        apb_xfer(1'b1, addr, wdata, rdata, err);
        assert (!err) else begin
            fail_now($sformatf("unexpected pslverr on write to address 0x%02h", addr));
        end
    endtask

    task automatic apb_read(input apb_addr_t addr, output apb_data_t rdata);
        logic err;
        apb_xfer(1'b0, addr, '0, rdata, err);
        assert (!err) else begin
            fail_now($sformatf("unexpected pslverr on read of address 0x%02h", addr));
        end
    endtask

    function automatic apb_addr_t stat_addr(input int ch);
        return (ch == 0) ? `CAL_ADDR_STAT0 : `CAL_ADDR_STAT1;
    endfunction

    function automatic void build_words(input int row);
        cal_data_t w;
        int        k;
        int        p;
        words_q.delete();
        for (k = 0; k < row_words[row]; k++) begin
            w = cal_data_t'(row_start[row] + k * row_step[row]);
            if (k + 1 == row_corrupt[row]) begin
                w = w ^ 8'h5a;
            end
            words_q.push_back(w);
        end
        // A swapped pair puts the pos-edge word on the neg edge and back.
        if (row_swap[row] != 0) begin
            p = 2 * (row_swap[row] - 1);
            w = words_q[p];
            words_q[p] = words_q[p + 1];
            words_q[p + 1] = w;
        end
    endfunction

    function automatic apb_data_t table_status(input int row);
        apb_data_t rep;
        rep = '0;
        rep[0] = 1'b1;
        rep[1] = row_exp_succ[row];
        rep[2] = row_exp_tmo[row];
        rep[8 +: `CAL_STREAK_W] = `CAL_STREAK_W'(row_exp_streak[row]);
        return rep;
    endfunction

    // Rounds end on word boundaries here because both-edge rows carry pairs.
    function automatic apb_data_t model_report(input int round_no);
        apb_data_t rep;
        cal_data_t prev;
        bit        have;
        bit        succ;
        bit        tmo;
        int        streak;
        int        total;
        int        rounds;
        int        k;
        rep    = '0;
        prev   = '0;
        have   = 1'b0;
        streak = 0;
        total  = 0;
        rounds = 0;
        for (k = 0; k < words_q.size(); k++) begin
            if (have && words_q[k] == cal_data_t'(prev + 1'b1)) begin
                if (streak < (1 << `CAL_STREAK_W) - 1) begin
                    streak++;
                end
            end else begin
                streak = 0;
            end
            have = 1'b1;
            prev = words_q[k];
            total++;
            succ = streak >= `CAL_THRESHOLD;
            tmo  = (total >= `CAL_TIMEOUT) && !succ;
            if (total % `CAL_WORDS_PER_ROUND == 0) begin
                rounds++;
                if (rounds == round_no) begin
                    rep[0] = 1'b1;
                    rep[1] = succ;
                    rep[2] = tmo;
                    rep[8 +: `CAL_STREAK_W] = `CAL_STREAK_W'(streak);
                end
            end
        end
        return rep;
    endfunction

    task automatic drive_words(input int ch, input logic nv, input cal_data_t nd,
                               input logic pv, input cal_data_t pd);
        if (ch != 1) begin
            neg0 <= {nv, nd};
            pos0 <= {pv, pd};
        end
        if (ch != 0) begin
            neg1 <= {nv, cal_data_t'(nd + CH1_OFFSET)};
            pos1 <= {pv, cal_data_t'(pd + CH1_OFFSET)};
        end
    endtask

    // Streams one round with random idle cycles and then leaves the inputs idle.
    task automatic drive_round(input int row, input int rnd);
        int idx;
        int last;
        int ch;
        idx  = rnd * `CAL_WORDS_PER_ROUND;
        last = idx + `CAL_WORDS_PER_ROUND;
        ch   = row_chan[row];
        while (idx < last) begin
            @(posedge clk);
            if ($urandom % 4 == 0) begin
                drive_words(ch, 1'b0, '0, 1'b0, '0);
            end else if (row_both[row]) begin
                drive_words(ch, 1'b1, words_q[idx], 1'b1, words_q[idx + 1]);
                idx += 2;
            end else if ($urandom % 2 == 0) begin
                drive_words(ch, 1'b1, words_q[idx], 1'b0, '0);
                idx += 1;
            end else begin
                drive_words(ch, 1'b0, '0, 1'b1, words_q[idx]);
                idx += 1;
            end
        end
        @(posedge clk);
        drive_words(ch, 1'b0, '0, 1'b0, '0);
    endtask

    task automatic wait_done(input int ch);
        apb_data_t st;
        int        polls;
        polls = 0;
        apb_read(stat_addr(ch), st);
        while (!st[0]) begin
            polls++;
            assert (polls < DONE_POLLS) else begin
                fail_now($sformatf("channel %0d never reported done", ch));
            end
            apb_read(stat_addr(ch), st);
        end
    endtask

    task automatic run_table();
        int         r;
        int         k;
        int         c;
        int         n_rounds;
        logic [1:0] mask;
        apb_data_t  exp_word;
        apb_data_t  st;
        string      tag;
        for (r = 0; r < NUM_ROWS; r++) begin
            build_words(r);
            n_rounds = row_words[r] / `CAL_WORDS_PER_ROUND;
            exp_word = table_status(r);
            check_eq({row_name[r], " reference model"}, exp_word, model_report(n_rounds));
            if (row_chan[r] == BOTH) begin
                mask = 2'b11;
            end else begin
                mask = 2'(1 << row_chan[r]);
            end
            apb_write(`CAL_ADDR_CTRL, 32'(mask));
            // The first report is polled for done and discarded. Later reports land on a
            // status word that already shows done, so they are read after the report latency.
            for (k = 0; k < n_rounds; k++) begin
                drive_round(r, k);
                if (k > 0) begin
                    repeat (REPORT_LATENCY) @(posedge clk);
                end else begin
                    for (c = 0; c < `CAL_NUM_CH; c++) begin
                        if (mask[c]) begin
                            wait_done(c);
                        end
                    end
                end
            end
            for (c = 0; c < `CAL_NUM_CH; c++) begin
                if (mask[c]) begin
                    tag = $sformatf("%s ch%0d", row_name[r], c);
                    apb_read(stat_addr(c), st);
                    check_eq({tag, " success"}, 32'(row_exp_succ[r]), 32'(st[1]));
                    check_eq({tag, " timed_out"}, 32'(row_exp_tmo[r]), 32'(st[2]));
                    check_eq({tag, " streak"}, 32'(row_exp_streak[r]), 32'(st[15:8]));
                    check_eq({tag, " status word"}, exp_word, st);
                end
            end
            apb_write(`CAL_ADDR_CTRL, 32'h0);
            for (c = 0; c < `CAL_NUM_CH; c++) begin
                if (mask[c]) begin
                    apb_read(stat_addr(c), st);
                    check_eq($sformatf("%s ch%0d cleared", row_name[r], c), 32'h0, st);
                end
            end
        end
    endtask

    task automatic check_apb_rules();
        apb_data_t rd;
        logic      err;
        apb_write(`CAL_ADDR_CTRL, 32'h3);
        apb_read(`CAL_ADDR_CTRL, rd);
        check_eq("ctrl readback both", 32'h3, rd);
        apb_write(`CAL_ADDR_CTRL, 32'h2);
        apb_read(`CAL_ADDR_CTRL, rd);
        check_eq("ctrl readback ch1", 32'h2, rd);
        apb_write(`CAL_ADDR_CTRL, 32'h0);
        // Status words are read only.
        apb_xfer(1'b1, `CAL_ADDR_STAT0, 32'hffff_ffff, rd, err);
        check_eq("stat0 write pslverr", 32'h1, 32'(err));
        apb_read(`CAL_ADDR_STAT0, rd);
        check_eq("stat0 unchanged", 32'h0, rd);
        apb_xfer(1'b0, 8'h0c, '0, rd, err);
        check_eq("unmapped read pslverr", 32'h1, 32'(err));
    endtask

    initial begin
        void'($urandom(32'he98a));
        reset   = 1'b1;
        paddr   = '0;
        psel    = 1'b0;
        penable = 1'b0;
        pwrite  = 1'b0;
        pwdata  = '0;
        neg0    = '0;
        pos0    = '0;
        neg1    = '0;
        pos1    = '0;
        repeat (3) @(posedge clk);
        reset <= 1'b0;
        run_table();
        check_apb_rules();
        $display("TEST PASSED");
        $finish;
    end

endmodule

// File: vlog.f
+incdir+.
cal_pkg.sv
cal_result_if.sv
fs_pattern_checker.sv
cal_result_arbiter.sv
cal_status_regs.sv
cal_monitor_top.sv
tb_cal_monitor.sv
